// ==== mem_subsys.f ====
rtl/cpu_cfg_pkg.sv
rtl/ms_bus_pkg.sv
rtl/req_ack_slot.sv
rtl/lsu_load.sv
rtl/lsu_store.sv
rtl/data_sram.sv
rtl/mem_stage.sv
rtl/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// ==== rtl/cpu_cfg_pkg.sv ====
// datapath widths and data SRAM geometry, imported by every RTL file of the memory subsystem
package cpu_cfg_pkg;

  // core datapath
  localparam int WORD_WD     = 64;
  localparam int GPR_ADDR_WD = 5;   // x0..x31
  localparam int CSR_ADDR_WD = 12;

  // data sram, one doubleword per entry
  localparam int SRAM_DATA_WD = 64;
  localparam int SRAM_ADDR_WD = 8;  // 256 doublewords

  // byte lanes per sram word
  localparam int SRAM_STRB_WD = SRAM_DATA_WD / 8;

  // low address bits that pick the byte lane
  localparam int SRAM_OFS_WD = $clog2(SRAM_STRB_WD);

endpackage

// ==== rtl/data_sram.sv ====
// private data memory of the memory stage, byte-strobed writes and one-cycle read latency
`timescale 1ns/1ps

module data_sram #(
  parameter int DEPTH = 1 << cpu_cfg_pkg::SRAM_ADDR_WD
) (
  input  logic                                 i_clk,
  input  logic                                 i_en,
  input  logic                                 i_wen,
  input  logic [cpu_cfg_pkg::SRAM_ADDR_WD-1:0] i_addr,
  input  logic [cpu_cfg_pkg::SRAM_STRB_WD-1:0] i_wstrb,
  input  logic [cpu_cfg_pkg::SRAM_DATA_WD-1:0] i_wdata,
  output logic [cpu_cfg_pkg::SRAM_DATA_WD-1:0] o_rdata
);

  import cpu_cfg_pkg::*;

  logic [SRAM_DATA_WD-1:0] mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_wen) begin
        for (int b = 0; b < SRAM_STRB_WD; b++) begin
          if (i_wstrb[b]) begin
            mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end else begin
        o_rdata <= mem[i_addr];  // holds until the next read
      end
    end
  end

endmodule

// ==== rtl/lsu_load.sv ====
// load data path of the memory stage: picks the byte lane and extends the loaded value
`timescale 1ns/1ps

module lsu_load (
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]      i_addr,
  input  logic [cpu_cfg_pkg::SRAM_DATA_WD-1:0] i_data_sram_rdata,
  input  ms_bus_pkg::mem_op_e                  i_mem_op,
  output logic [cpu_cfg_pkg::WORD_WD-1:0]      o_rdata
);

  import cpu_cfg_pkg::*;
  import ms_bus_pkg::*;

  logic [SRAM_OFS_WD-1:0]  ofs;
  logic [SRAM_DATA_WD-1:0] lane;

  assign ofs  = i_addr[SRAM_OFS_WD-1:0];
  assign lane = i_data_sram_rdata >> {ofs, 3'b000};  // addressed byte to bit 0

  always_comb begin
    case (i_mem_op)
      LB: begin
        o_rdata = {{(WORD_WD-8){lane[7]}}, lane[7:0]};
      end
      LH: begin
        o_rdata = {{(WORD_WD-16){lane[15]}}, lane[15:0]};
      end
      LW: begin
        o_rdata = {{(WORD_WD-32){lane[31]}}, lane[31:0]};
      end
      LBU: begin
        o_rdata = {{(WORD_WD-8){1'b0}}, lane[7:0]};
      end
      LHU: begin
        o_rdata = {{(WORD_WD-16){1'b0}}, lane[15:0]};
      end
      LWU: begin
        o_rdata = {{(WORD_WD-32){1'b0}}, lane[31:0]};
      end
      LD: begin
        o_rdata = lane[WORD_WD-1:0];
      end
      default: begin
        o_rdata = lane[WORD_WD-1:0];  // 3'b111 is not a load
      end
    endcase
  end

endmodule

// ==== rtl/lsu_store.sv ====
// store data path of the memory stage: byte strobes and lane-shifted write data for the SRAM
`timescale 1ns/1ps

module lsu_store (
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]      i_addr,
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]      i_store_data,
  input  ms_bus_pkg::mem_op_e                  i_mem_op,
  output logic [cpu_cfg_pkg::SRAM_STRB_WD-1:0] o_wstrb,
  output logic [cpu_cfg_pkg::SRAM_DATA_WD-1:0] o_wdata
);

  import cpu_cfg_pkg::*;
  import ms_bus_pkg::*;

  logic [SRAM_OFS_WD-1:0]  ofs;
  logic [SRAM_STRB_WD-1:0] size_strb;

  assign ofs = i_addr[SRAM_OFS_WD-1:0];

  // strobe for the access size at lane 0
  always_comb begin
    case (i_mem_op)
      SB: begin
        size_strb = 8'h01;
      end
      SH: begin
        size_strb = 8'h03;
      end
      SW: begin
        size_strb = 8'h0f;
      end
      SD: begin
        size_strb = 8'hff;
      end
      default: begin
        size_strb = 8'h00;  // no bytes for non-store codes
      end
    endcase
  end

  assign o_wstrb = size_strb << ofs;

  // bytes outside the strobe are don't care
  assign o_wdata = SRAM_DATA_WD'(i_store_data) << {ofs, 3'b000};

endmodule

// ==== rtl/mem_stage.sv ====
// memory access stage: runs the load or store on the data SRAM and builds the writeback payload
`timescale 1ns/1ps

module mem_stage (
  input  logic                                 i_clk,
  input  logic                                 i_arst_n,
  // from es slot
  input  logic                                 i_in_req,
  output logic                                 o_in_ack,
  input  ms_bus_pkg::es_to_ms_t                i_in_data,
  // to ws slot
  output logic                                 o_out_req,
  input  logic                                 i_out_ack,
  output ms_bus_pkg::ms_to_ws_t                o_out_data,
  // data sram
  output logic                                 o_sram_en,
  output logic                                 o_sram_wen,
  output logic [cpu_cfg_pkg::SRAM_ADDR_WD-1:0] o_sram_addr,
  output logic [cpu_cfg_pkg::SRAM_STRB_WD-1:0] o_sram_wstrb,
  output logic [cpu_cfg_pkg::SRAM_DATA_WD-1:0] o_sram_wdata,
  input  logic [cpu_cfg_pkg::SRAM_DATA_WD-1:0] i_sram_rdata
);

  import cpu_cfg_pkg::*;
  import ms_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_WAIT_RD,
    ST_SEND,
    ST_RELEASE
  } state_e;

  state_e             state_q;
  logic               in_ack_q;
  logic               capture;
  es_to_ms_t          ms_q;
  logic [WORD_WD-1:0] memrdata;
  logic [WORD_WD-1:0] ld_data_q;
  logic [WORD_WD-1:0] gpr_result;
  logic               misalign;

  assign capture = (state_q == ST_IDLE) && i_in_req && !in_ack_q;

  // input handshake runs on its own once the item is taken
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_ack_q <= 1'b0;
    end else if (capture) begin
      in_ack_q <= 1'b1;
    end else if (!i_in_req) begin
      in_ack_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:    if (capture) state_q <= ST_ACCESS;
        ST_ACCESS:  state_q <= ms_q.mem_ren ? ST_WAIT_RD : ST_SEND;
        ST_WAIT_RD: state_q <= ST_SEND;  // sram latency
        ST_SEND:    if (i_out_ack) state_q <= ST_RELEASE;
        ST_RELEASE: if (!i_out_ack) state_q <= ST_IDLE;
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (capture) begin
      ms_q <= i_in_data;
    end
    if (state_q == ST_WAIT_RD) begin
      ld_data_q <= memrdata;
    end
  end

  // sram access issued from the captured instruction
  assign o_sram_en   = (state_q == ST_ACCESS) && (ms_q.mem_ren || ms_q.mem_wen);
  assign o_sram_wen  = (state_q == ST_ACCESS) && ms_q.mem_wen;
  assign o_sram_addr = ms_q.alu_result[SRAM_OFS_WD +: SRAM_ADDR_WD];  // doubleword index

  lsu_store u_lsu_store (
    .i_addr       (ms_q.alu_result),
    .i_store_data (ms_q.store_data),
    .i_mem_op     (ms_q.mem_op),
    .o_wstrb      (o_sram_wstrb),
    .o_wdata      (o_sram_wdata)
  );

  lsu_load u_lsu_load (
    .i_addr            (ms_q.alu_result),
    .i_data_sram_rdata (i_sram_rdata),
    .i_mem_op          (ms_q.mem_op),
    .o_rdata           (memrdata)
  );

  assign gpr_result = ms_q.mem_ren
                    ? ld_data_q
                    : (ms_q.csr_inst_sel ? ms_q.csrrdata : ms_q.alu_result);

  always_comb begin
    o_out_data.gpr_wen    = ms_q.gpr_wen;
    o_out_data.rd         = ms_q.rd;
    o_out_data.gpr_result = gpr_result;
    o_out_data.csr_wen    = ms_q.csr_wen;
    o_out_data.csr        = ms_q.csr;
    o_out_data.csr_result = ms_q.csr_result;  // unchanged
  end

  assign o_in_ack  = in_ack_q;
  assign o_out_req = (state_q == ST_SEND);

  // natural alignment by access size
  always_comb begin
    case (ms_q.mem_op[1:0])
      2'b00:   misalign = 1'b0;
      2'b01:   misalign = ms_q.alu_result[0];
      2'b10:   misalign = |ms_q.alu_result[1:0];
      default: misalign = |ms_q.alu_result[2:0];
    endcase
  end

  a_ren_wen_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (state_q != ST_IDLE) |-> !(ms_q.mem_ren && ms_q.mem_wen));

  // misaligned accesses have no trap path
  a_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_sram_en |-> !misalign);

endmodule

// ==== rtl/mem_subsys_top.sv ====
// memory subsystem top: input slot, memory stage, output slot and data SRAM behind loose ports
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                                i_clk,
  input  logic                                i_arst_n,
  // from execute
  input  logic                                i_es_req,
  output logic                                o_es_ack,
  input  logic [cpu_cfg_pkg::GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                                i_es_gpr_wen,
  input  logic [cpu_cfg_pkg::CSR_ADDR_WD-1:0] i_es_csr,
  input  logic                                i_es_csr_wen,
  input  logic                                i_es_mem_ren,
  input  logic                                i_es_mem_wen,
  input  ms_bus_pkg::mem_op_e                 i_es_mem_op,
  input  logic                                i_es_csr_inst_sel,
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]     i_es_csrrdata,
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]     i_es_alu_result,
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]     i_es_csr_result,
  input  logic [cpu_cfg_pkg::WORD_WD-1:0]     i_es_store_data,
  // to writeback
  output logic                                o_ws_req,
  input  logic                                i_ws_ack,
  output logic                                o_ws_gpr_wen,
  output logic [cpu_cfg_pkg::GPR_ADDR_WD-1:0] o_ws_rd,
  output logic [cpu_cfg_pkg::WORD_WD-1:0]     o_ws_gpr_result,
  output logic                                o_ws_csr_wen,
  output logic [cpu_cfg_pkg::CSR_ADDR_WD-1:0] o_ws_csr,
  output logic [cpu_cfg_pkg::WORD_WD-1:0]     o_ws_csr_result
);

  import cpu_cfg_pkg::*;
  import ms_bus_pkg::*;

  es_to_ms_t               es_data;
  es_to_ms_t               ms_in_data;
  ms_to_ws_t               ms_out_data;
  ms_to_ws_t               ws_data;
  logic                    ms_in_req;
  logic                    ms_in_ack;
  logic                    ms_out_req;
  logic                    ms_out_ack;
  logic                    sram_en;
  logic                    sram_wen;
  logic [SRAM_ADDR_WD-1:0] sram_addr;
  logic [SRAM_STRB_WD-1:0] sram_wstrb;
  logic [SRAM_DATA_WD-1:0] sram_wdata;
  logic [SRAM_DATA_WD-1:0] sram_rdata;

  assign es_data = '{
    rd:           i_es_rd,
    gpr_wen:      i_es_gpr_wen,
    csr:          i_es_csr,
    csr_wen:      i_es_csr_wen,
    mem_ren:      i_es_mem_ren,
    mem_wen:      i_es_mem_wen,
    mem_op:       i_es_mem_op,
    csr_inst_sel: i_es_csr_inst_sel,
    csrrdata:     i_es_csrrdata,
    alu_result:   i_es_alu_result,
    csr_result:   i_es_csr_result,
    store_data:   i_es_store_data
  };

  req_ack_slot #(.T(es_to_ms_t)) u_in_slot (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (i_es_req),
    .o_ack    (o_es_ack),
    .i_data   (es_data),
    .o_req    (ms_in_req),
    .i_ack    (ms_in_ack),
    .o_data   (ms_in_data)
  );

  mem_stage u_mem_stage (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_in_req     (ms_in_req),
    .o_in_ack     (ms_in_ack),
    .i_in_data    (ms_in_data),
    .o_out_req    (ms_out_req),
    .i_out_ack    (ms_out_ack),
    .o_out_data   (ms_out_data),
    .o_sram_en    (sram_en),
    .o_sram_wen   (sram_wen),
    .o_sram_addr  (sram_addr),
    .o_sram_wstrb (sram_wstrb),
    .o_sram_wdata (sram_wdata),
    .i_sram_rdata (sram_rdata)
  );

  data_sram u_data_sram (
    .i_clk   (i_clk),
    .i_en    (sram_en),
    .i_wen   (sram_wen),
    .i_addr  (sram_addr),
    .i_wstrb (sram_wstrb),
    .i_wdata (sram_wdata),
    .o_rdata (sram_rdata)
  );

  req_ack_slot #(.T(ms_to_ws_t)) u_out_slot (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (ms_out_req),
    .o_ack    (ms_out_ack),
    .i_data   (ms_out_data),
    .o_req    (o_ws_req),
    .i_ack    (i_ws_ack),
    .o_data   (ws_data)
  );

  assign o_ws_gpr_wen    = ws_data.gpr_wen;
  assign o_ws_rd         = ws_data.rd;
  assign o_ws_gpr_result = ws_data.gpr_result;
  assign o_ws_csr_wen    = ws_data.csr_wen;
  assign o_ws_csr        = ws_data.csr;
  assign o_ws_csr_result = ws_data.csr_result;

endmodule

// ==== rtl/ms_bus_pkg.sv ====
// load/store op encodings and the es->ms and ms->ws payload structs used by the memory stage
package ms_bus_pkg;

  // funct3 of a memory access
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110
  } mem_op_e;

  // stores reuse the size codes of the loads
  localparam mem_op_e SB = LB;
  localparam mem_op_e SH = LH;
  localparam mem_op_e SW = LW;
  localparam mem_op_e SD = LD;

  typedef struct packed {
    logic [cpu_cfg_pkg::GPR_ADDR_WD-1:0] rd;
    logic                                gpr_wen;
    logic [cpu_cfg_pkg::CSR_ADDR_WD-1:0] csr;
    logic                                csr_wen;
    logic                                mem_ren;
    logic                                mem_wen;
    mem_op_e                             mem_op;
    logic                                csr_inst_sel;  // write csrrdata to gpr
    logic [cpu_cfg_pkg::WORD_WD-1:0]     csrrdata;
    logic [cpu_cfg_pkg::WORD_WD-1:0]     alu_result;    // also the mem address
    logic [cpu_cfg_pkg::WORD_WD-1:0]     csr_result;
    logic [cpu_cfg_pkg::WORD_WD-1:0]     store_data;
  } es_to_ms_t;

  typedef struct packed {
    logic                                gpr_wen;
    logic [cpu_cfg_pkg::GPR_ADDR_WD-1:0] rd;
    logic [cpu_cfg_pkg::WORD_WD-1:0]     gpr_result;
    logic                                csr_wen;
    logic [cpu_cfg_pkg::CSR_ADDR_WD-1:0] csr;
    logic [cpu_cfg_pkg::WORD_WD-1:0]     csr_result;
  } ms_to_ws_t;

endpackage

// ==== rtl/req_ack_slot.sv ====
// one-entry buffer between two four-phase req/ack links, instantiated once per payload type
`timescale 1ns/1ps

module req_ack_slot #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_arst_n,
  // receive side
  input  logic i_req,
  output logic o_ack,
  input  T     i_data,
  // send side
  output logic o_req,
  input  logic i_ack,
  output T     o_data
);

  typedef enum logic [1:0] {
    SND_EMPTY,
    SND_ARM,
    SND_REQ,
    SND_REL
  } snd_e;

  snd_e snd_q;
  logic ack_q;
  logic capture;
  T     data_q;

  // take a new item only once the previous one is fully handed off
  assign capture = i_req && !ack_q && (snd_q == SND_EMPTY);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q <= 1'b0;
    end else if (capture) begin
      ack_q <= 1'b1;
    end else if (!i_req) begin
      ack_q <= 1'b0;  // req fell
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      snd_q <= SND_EMPTY;
    end else begin
      case (snd_q)
        SND_EMPTY: if (capture) snd_q <= SND_ARM;
        SND_ARM:   snd_q <= SND_REQ;
        SND_REQ:   if (i_ack) snd_q <= SND_REL;
        SND_REL:   if (!i_ack) snd_q <= SND_EMPTY;
        default:   snd_q <= SND_EMPTY;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (capture) begin
      data_q <= i_data;
    end
  end

  assign o_ack  = ack_q;
  assign o_req  = (snd_q == SND_REQ);
  assign o_data = data_q;

  // upstream keeps data steady until we ack
  a_data_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_req && !o_ack) |=> $stable(i_data));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks its verdict line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsys -f mem_subsys.f \
  && ./obj_dir/Vtb_mem_subsys | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

// ==== sim/tb_mem_subsys.sv ====
// directed testbench for mem_subsys_top, built from mem_subsys.f with tb_mem_subsys as top
`timescale 1ns/1ps

module tb_mem_subsys;

  import cpu_cfg_pkg::*;
  import ms_bus_pkg::*;

  localparam int          CLK_PERIOD  = 10;
  localparam int          RST_CYCLES  = 4;
  localparam logic [15:0] LFSR_SEED   = 16'd21553;
  localparam int          BYTE_AW     = SRAM_ADDR_WD + SRAM_OFS_WD;
  localparam int          N_RT        = 8;
  localparam int          N_MERGE     = 5;
  localparam int          N_EXT       = 16;
  localparam int          N_SEL       = 6;
  localparam int          N_BURST     = 16;
  localparam int          N_XFERS     = 2 * N_RT + N_MERGE + N_EXT + N_SEL + N_BURST;
  localparam int          XFER_CYCLES = 60;  // covers the slowest downstream ack
  localparam int          HS_LIMIT    = 400;

  logic                   i_clk;
  logic                   i_arst_n;
  logic                   i_es_req;
  logic                   o_es_ack;
  logic [GPR_ADDR_WD-1:0] i_es_rd;
  logic                   i_es_gpr_wen;
  logic [CSR_ADDR_WD-1:0] i_es_csr;
  logic                   i_es_csr_wen;
  logic                   i_es_mem_ren;
  logic                   i_es_mem_wen;
  mem_op_e                i_es_mem_op;
  logic                   i_es_csr_inst_sel;
  logic [WORD_WD-1:0]     i_es_csrrdata;
  logic [WORD_WD-1:0]     i_es_alu_result;
  logic [WORD_WD-1:0]     i_es_csr_result;
  logic [WORD_WD-1:0]     i_es_store_data;
  logic                   o_ws_req;
  logic                   i_ws_ack;
  logic                   o_ws_gpr_wen;
  logic [GPR_ADDR_WD-1:0] o_ws_rd;
  logic [WORD_WD-1:0]     o_ws_gpr_result;
  logic                   o_ws_csr_wen;
  logic [CSR_ADDR_WD-1:0] o_ws_csr;
  logic [WORD_WD-1:0]     o_ws_csr_result;

  logic [7:0]  ref_mem [1 << BYTE_AW];  // byte image of the data sram
  logic [15:0] lfsr_q;
  ms_to_ws_t   exp_q[$];
  string       name_q[$];
  string       cur_test;
  int          ack_delay;
  int          err_main = 0;
  int          err_recv = 0;
  int          err_mon = 0;
  int          chk_main = 0;
  int          chk_recv = 0;
  int          chk_mon = 0;
  int          n_tests = 0;
  int          held = 0;
  logic        es_ack_d = 1'b0;
  logic        ws_ack_d = 1'b0;

  mem_subsys_top DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  function automatic logic lfsr_bit();
    lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    return lfsr_q[0];
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < 64; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic int total_errors();
    return err_main + err_recv + err_mon;
  endfunction

  function automatic void ref_store(input mem_op_e op, input logic [63:0] addr,
                                    input logic [63:0] data);
    logic [BYTE_AW-1:0] ba;
    for (int i = 0; i < (1 << op[1:0]); i++) begin
      ba = addr[BYTE_AW-1:0] + BYTE_AW'(i);
      ref_mem[ba] = data[i*8 +: 8];
    end
  endfunction

  function automatic logic [63:0] ref_load(input mem_op_e op, input logic [63:0] addr);
    logic [63:0]        raw;
    logic [BYTE_AW-1:0] ba;
    raw = '0;
    for (int i = 0; i < (1 << op[1:0]); i++) begin
      ba = addr[BYTE_AW-1:0] + BYTE_AW'(i);
      raw[i*8 +: 8] = ref_mem[ba];  // little endian
    end
    case (op)
      LB:      return {{56{raw[7]}}, raw[7:0]};
      LH:      return {{48{raw[15]}}, raw[15:0]};
      LW:      return {{32{raw[31]}}, raw[31:0]};
      default: return raw;  // upper bytes already zero
    endcase
  endfunction

  function automatic es_to_ms_t load_item(input mem_op_e op, input logic [63:0] addr,
                                          input logic [4:0] rd);
    es_to_ms_t t;
    t            = '0;
    t.mem_ren    = 1'b1;
    t.mem_op     = op;
    t.alu_result = addr;
    t.gpr_wen    = 1'b1;
    t.rd         = rd;
    return t;
  endfunction

  function automatic es_to_ms_t store_item(input mem_op_e op, input logic [63:0] addr,
                                           input logic [63:0] data);
    es_to_ms_t t;
    t            = '0;
    t.mem_wen    = 1'b1;
    t.mem_op     = op;
    t.alu_result = addr;
    t.store_data = data;
    return t;
  endfunction

  function automatic es_to_ms_t alu_item(input logic sel, input logic [63:0] csrrd,
                                         input logic [63:0] alu, input logic [11:0] csr,
                                         input logic [63:0] csr_res, input logic [4:0] rd);
    es_to_ms_t t;
    t              = '0;
    t.mem_op       = LD;
    t.csr_inst_sel = sel;
    t.csrrdata     = csrrd;
    t.alu_result   = alu;
    t.csr          = csr;
    t.csr_wen      = 1'b1;
    t.csr_result   = csr_res;
    t.gpr_wen      = 1'b1;
    t.rd           = rd;
    return t;
  endfunction

  // expected writeback, and the store goes into the byte image
  function automatic ms_to_ws_t model_op(input es_to_ms_t t);
    ms_to_ws_t e;
    e.gpr_wen    = t.gpr_wen;
    e.rd         = t.rd;
    e.csr_wen    = t.csr_wen;
    e.csr        = t.csr;
    e.csr_result = t.csr_result;
    if (t.mem_wen) begin
      ref_store(t.mem_op, t.alu_result, t.store_data);
    end
    if (t.mem_ren) begin
      e.gpr_result = ref_load(t.mem_op, t.alu_result);
    end else if (t.csr_inst_sel) begin
      e.gpr_result = t.csrrdata;
    end else begin
      e.gpr_result = t.alu_result;
    end
    return e;
  endfunction

  task automatic send_op(input es_to_ms_t t);
    int n;
    exp_q.push_back(model_op(t));
    name_q.push_back(cur_test);
    @(negedge i_clk);
    i_es_rd           = t.rd;
    i_es_gpr_wen      = t.gpr_wen;
    i_es_csr          = t.csr;
    i_es_csr_wen      = t.csr_wen;
    i_es_mem_ren      = t.mem_ren;
    i_es_mem_wen      = t.mem_wen;
    i_es_mem_op       = t.mem_op;
    i_es_csr_inst_sel = t.csr_inst_sel;
    i_es_csrrdata     = t.csrrdata;
    i_es_alu_result   = t.alu_result;
    i_es_csr_result   = t.csr_result;
    i_es_store_data   = t.store_data;
    i_es_req          = 1'b1;
    n = 0;
    while (!o_es_ack && n < HS_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    assert (o_es_ack) else begin
      $display("%s: input side never acknowledged the request", cur_test);
      err_main++;
    end
    i_es_req = 1'b0;
    n = 0;
    while (o_es_ack && n < HS_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    assert (!o_es_ack) else begin
      $display("%s: input ack stayed high after req was dropped", cur_test);
      err_main++;
    end
  endtask

  task automatic recv_one();
    ms_to_ws_t act;
    ms_to_ws_t exp;
    string     tname;
    int        n;
    while (o_ws_req !== 1'b1) begin
      @(negedge i_clk);
    end
    repeat (ack_delay) @(negedge i_clk);
    act.gpr_wen    = o_ws_gpr_wen;
    act.rd         = o_ws_rd;
    act.gpr_result = o_ws_gpr_result;
    act.csr_wen    = o_ws_csr_wen;
    act.csr        = o_ws_csr;
    act.csr_result = o_ws_csr_result;
    i_ws_ack = 1'b1;
    assert (exp_q.size() != 0) else begin
      $display("unexpected extra result on the output side, rd %0d", act.rd);
      err_recv++;
    end
    if (exp_q.size() != 0) begin
      exp   = exp_q.pop_front();
      tname = name_q.pop_front();
      chk_recv++;
      assert (act == exp) else begin
        $display("CHECK FAILED %s: expected %h, actual %h", tname, exp, act);
        err_recv++;
      end
    end
    n = 0;
    while (o_ws_req && n < HS_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    assert (!o_ws_req) else begin
      $display("output req never dropped after ack");
      err_recv++;
    end
    i_ws_ack = 1'b0;
  endtask

  task automatic end_test(input int e0);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || i_ws_ack) && n < N_BURST * XFER_CYCLES) begin
      @(negedge i_clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d results never came out", cur_test, exp_q.size());
      err_main++;
    end
    n_tests++;
    $display("test %-20s %0d errors", cur_test, total_errors() - e0);
  endtask

  task automatic reset_values();
    int e0;
    cur_test = "reset_values";
    e0 = total_errors();
    @(negedge i_clk);
    chk_main += 2;
    assert (o_es_ack == 1'b0) else begin
      $display("CHECK FAILED %s: o_es_ack expected 0, actual %b", cur_test, o_es_ack);
      err_main++;
    end
    assert (o_ws_req == 1'b0) else begin
      $display("CHECK FAILED %s: o_ws_req expected 0, actual %b", cur_test, o_ws_req);
      err_main++;
    end
    end_test(e0);
  endtask

  task automatic dword_round_trip();
    int e0;
    cur_test = "dword_round_trip";
    e0 = total_errors();
    ack_delay = 0;
    for (int k = 0; k < N_RT; k++) begin
      send_op(store_item(SD, 64'h48 * 64'(k), rand64()));
    end
    for (int k = 0; k < N_RT; k++) begin
      send_op(load_item(LD, 64'h48 * 64'(k), 5'(k + 1)));
    end
    end_test(e0);
  endtask

  task automatic subword_merge();
    int e0;
    cur_test = "subword_merge";
    e0 = total_errors();
    ack_delay = 2;
    send_op(store_item(SD, 64'h300, rand64()));
    send_op(store_item(SW, 64'h300, rand64()));
    send_op(store_item(SB, 64'h305, rand64()));  // upper bits are junk
    send_op(store_item(SH, 64'h306, rand64()));
    send_op(load_item(LD, 64'h300, 5'd9));
    end_test(e0);
  endtask

  task automatic load_extension();
    int e0;
    cur_test = "load_extension";
    e0 = total_errors();
    ack_delay = 1;
    send_op(store_item(SD, 64'h380, 64'h0123_7654_80a5_f07f));
    send_op(store_item(SD, 64'h388, 64'h8765_4321_7fff_8001));
    send_op(load_item(LB,  64'h380, 5'd1));  // 7f
    send_op(load_item(LB,  64'h381, 5'd2));  // f0
    send_op(load_item(LBU, 64'h381, 5'd3));
    send_op(load_item(LH,  64'h382, 5'd4));  // 80a5
    send_op(load_item(LHU, 64'h382, 5'd5));
    send_op(load_item(LH,  64'h384, 5'd6));
    send_op(load_item(LW,  64'h380, 5'd7));
    send_op(load_item(LWU, 64'h380, 5'd8));
    send_op(load_item(LW,  64'h384, 5'd9));
    send_op(load_item(LW,  64'h38c, 5'd10));  // 87654321
    send_op(load_item(LWU, 64'h38c, 5'd11));
    send_op(load_item(LH,  64'h388, 5'd12));
    send_op(load_item(LHU, 64'h388, 5'd13));
    send_op(load_item(LBU, 64'h38b, 5'd14));
    end_test(e0);
  endtask

  task automatic csr_alu_select();
    int e0;
    cur_test = "csr_alu_select";
    e0 = total_errors();
    ack_delay = 3;
    for (int k = 0; k < N_SEL; k++) begin
      send_op(alu_item(k % 2 == 0, rand64(), rand64(), 12'(12'h300 + k), rand64(), 5'(k + 16)));
    end
    end_test(e0);
  endtask

  task automatic backpressure_burst();
    int e0;
    cur_test = "backpressure_burst";
    e0 = total_errors();
    ack_delay = 12;  // slow writeback fills all three places
    for (int i = 0; i < N_BURST; i++) begin
      case (i % 4)
        0: send_op(store_item(SD, 64'h400 + 64'(8 * i), rand64()));
        1: send_op(load_item(LD, 64'h400 + 64'(8 * (i - 1)), 5'(i)));
        2: send_op(load_item(LWU, 64'h48 * 64'(i % N_RT) + 64'd4, 5'(i)));
        default: send_op(alu_item(lfsr_bit(), rand64(), rand64(), 12'(i), rand64(), 5'(i)));
      endcase
    end
    end_test(e0);
    ack_delay = 0;
  endtask

  // items accepted but not yet taken downstream
  always @(posedge i_clk) begin
    if (i_arst_n) begin
      if (o_es_ack && !es_ack_d) begin
        chk_mon++;
        assert (held < 3) else begin
          $display("%s: input accepted an item while all three places were full", cur_test);
          err_mon++;
        end
        held++;
      end
      if (i_ws_ack && !ws_ack_d) begin
        held--;
      end
    end
    es_ack_d = o_es_ack;
    ws_ack_d = i_ws_ack;
  end

  initial begin
    i_ws_ack = 1'b0;
    forever begin
      recv_one();
    end
  end

  initial begin
    repeat (RST_CYCLES + N_XFERS * XFER_CYCLES) @(posedge i_clk);
    $display("timeout: run did not finish within %0d cycles",
             RST_CYCLES + N_XFERS * XFER_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    i_arst_n          = 1'b0;
    i_es_req          = 1'b0;
    i_es_rd           = '0;
    i_es_gpr_wen      = 1'b0;
    i_es_csr          = '0;
    i_es_csr_wen      = 1'b0;
    i_es_mem_ren      = 1'b0;
    i_es_mem_wen      = 1'b0;
    i_es_mem_op       = LB;
    i_es_csr_inst_sel = 1'b0;
    i_es_csrrdata     = '0;
    i_es_alu_result   = '0;
    i_es_csr_result   = '0;
    i_es_store_data   = '0;
    lfsr_q            = LFSR_SEED;
    ack_delay         = 0;
    repeat (RST_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    reset_values();
    dword_round_trip();
    subword_merge();
    load_extension();
    csr_alu_select();
    backpressure_burst();
    $display("tests %0d, checks %0d, errors %0d", n_tests,
             chk_main + chk_recv + chk_mon, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
